// File: id_pkg.sv
// decode stage widths, field types, opcode, alu, branch and operand-select constants
package id_pkg;

  typedef logic [63:0] xlen_t;      // data, pc, immediate
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  gpr_addr_t;
  typedef logic [6:0]  opcode_t;

  // {funct7[5], funct3} for the OP family, add otherwise
  typedef logic [3:0]  alu_op_t;

  typedef logic [2:0]  br_func_t;   // funct3 of the branch
  typedef logic [2:0]  mem_op_t;    // funct3 of load/store, size and sign
  typedef logic [1:0]  src2_sel_t;

  localparam alu_op_t ALU_ADD = 4'd0;

  // alu operand 2
  localparam src2_sel_t SRC2_RS2  = 2'd0;
  localparam src2_sel_t SRC2_IMM  = 2'd1;
  localparam src2_sel_t SRC2_FOUR = 2'd2;  // link address pc + 4

  // branch conditions, straight from funct3
  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

  // rv64i major opcodes
  localparam opcode_t OPC_LUI     = 7'b0110111;
  localparam opcode_t OPC_AUIPC   = 7'b0010111;
  localparam opcode_t OPC_JAL     = 7'b1101111;
  localparam opcode_t OPC_JALR    = 7'b1100111;
  localparam opcode_t OPC_BRANCH  = 7'b1100011;
  localparam opcode_t OPC_LOAD    = 7'b0000011;
  localparam opcode_t OPC_STORE   = 7'b0100011;
  localparam opcode_t OPC_OPIMM   = 7'b0010011;
  localparam opcode_t OPC_OP      = 7'b0110011;
  localparam opcode_t OPC_OPIMM32 = 7'b0011011;  // addiw, slliw, ...
  localparam opcode_t OPC_OP32    = 7'b0111011;  // addw, subw, ...

  localparam gpr_addr_t GPR_ZERO = 5'd0;

endpackage

// File: dec_if.sv
// decoded-field interface between decoder and issue logic
`timescale 1ns/1ns

interface dec_if
  import id_pkg::*;
();

  gpr_addr_t rs1;
  gpr_addr_t rs2;
  gpr_addr_t rd;
  xlen_t     imm;
  logic      br_en;
  logic      jump;
  logic      jump_reg;       // jalr, target from rs1
  br_func_t  br_func;
  alu_op_t   alu_op;
  logic      alu_src1_pc;
  logic      alu_src1_zero;  // lui
  src2_sel_t alu_src2;
  logic      alu_word;       // 32-bit op, sign-extend result
  logic      gpr_we;
  logic      mem_re;
  logic      mem_we;
  mem_op_t   mem_op;
  logic      invalid;

  modport producer (
    output rs1, rs2, rd, imm, br_en, jump, jump_reg, br_func, alu_op,
           alu_src1_pc, alu_src1_zero, alu_src2, alu_word, gpr_we,
           mem_re, mem_we, mem_op, invalid
  );

  modport consumer (
    input  rs1, rs2, rd, imm, br_en, jump, jump_reg, br_func, alu_op,
           alu_src1_pc, alu_src1_zero, alu_src2, alu_word, gpr_we,
           mem_re, mem_we, mem_op, invalid
  );

endinterface

// File: id_latch.sv
// decode stage latch, valid bit and fetched instruction/pc register
`timescale 1ns/1ns

module id_latch
  import id_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst_n,
  input  logic  i_fs_to_ds_valid,
  input  logic  i_allowin,
  input  inst_t i_fs_inst,
  input  xlen_t i_fs_pc,
  output logic  o_valid,
  output inst_t o_inst,
  output xlen_t o_pc
);

  logic  valid_q;
  inst_t inst_q;
  xlen_t pc_q;

  // a bubble from fetch empties the stage when it may move
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (i_allowin) begin
      valid_q <= i_fs_to_ds_valid;
    end
  end

  // only a real handoff replaces the held instruction
  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && i_allowin) begin
      inst_q <= i_fs_inst;
      pc_q   <= i_fs_pc;
    end
  end

  assign o_valid = valid_q;
  assign o_inst  = inst_q;
  assign o_pc    = pc_q;

endmodule

// File: id_decoder.sv
// rv64i field extraction, immediate generation and control decode
`timescale 1ns/1ns

module id_decoder
  import id_pkg::*;
(
  input  inst_t       i_inst,
  dec_if.producer     o_dec
);

  opcode_t     opcode;
  logic [2:0]  funct3;
  logic        funct7_b5;
  xlen_t       imm_i;
  xlen_t       imm_s;
  xlen_t       imm_b;
  xlen_t       imm_u;
  xlen_t       imm_j;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];

  // sign-extended immediates of every format
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // fixed field positions, hazard logic compares them unconditionally
  assign o_dec.rs1     = i_inst[19:15];
  assign o_dec.rs2     = i_inst[24:20];
  assign o_dec.rd      = i_inst[11:7];
  assign o_dec.br_func = funct3;
  assign o_dec.mem_op  = funct3;

  always_comb begin
    o_dec.imm           = '0;
    o_dec.br_en         = 1'b0;
    o_dec.jump          = 1'b0;
    o_dec.jump_reg      = 1'b0;
    o_dec.alu_op        = ALU_ADD;
    o_dec.alu_src1_pc   = 1'b0;
    o_dec.alu_src1_zero = 1'b0;
    o_dec.alu_src2      = SRC2_IMM;
    o_dec.alu_word      = 1'b0;
    o_dec.gpr_we        = 1'b0;
    o_dec.mem_re        = 1'b0;
    o_dec.mem_we        = 1'b0;
    o_dec.invalid       = 1'b0;

    case (opcode)
      OPC_LUI: begin
        o_dec.imm           = imm_u;
        o_dec.alu_src1_zero = 1'b1;  // 0 + imm
        o_dec.gpr_we        = 1'b1;
      end
      OPC_AUIPC: begin
        o_dec.imm         = imm_u;
        o_dec.alu_src1_pc = 1'b1;
        o_dec.gpr_we      = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        o_dec.imm         = (opcode == OPC_JAL) ? imm_j : imm_i;
        o_dec.jump        = 1'b1;
        o_dec.jump_reg    = (opcode == OPC_JALR);
        o_dec.alu_src1_pc = 1'b1;       // link value pc + 4
        o_dec.alu_src2    = SRC2_FOUR;
        o_dec.gpr_we      = 1'b1;
      end
      OPC_BRANCH: begin
        o_dec.imm      = imm_b;
        o_dec.br_en    = 1'b1;
        o_dec.alu_src2 = SRC2_RS2;
      end
      OPC_LOAD: begin
        o_dec.imm    = imm_i;
        o_dec.mem_re = 1'b1;
        o_dec.gpr_we = 1'b1;
      end
      OPC_STORE: begin
        o_dec.imm    = imm_s;
        o_dec.mem_we = 1'b1;
      end
      OPC_OPIMM, OPC_OPIMM32: begin
        o_dec.imm      = imm_i;
        // bit 30 only selects srai, elsewhere it is immediate
        o_dec.alu_op   = {(funct3 == 3'b101) & funct7_b5, funct3};
        o_dec.alu_word = (opcode == OPC_OPIMM32);
        o_dec.gpr_we   = 1'b1;
      end
      OPC_OP, OPC_OP32: begin
        o_dec.alu_op   = {((funct3 == 3'b000) || (funct3 == 3'b101)) & funct7_b5, funct3};
        o_dec.alu_src2 = SRC2_RS2;
        o_dec.alu_word = (opcode == OPC_OP32);
        o_dec.gpr_we   = 1'b1;
      end
      default: begin
        o_dec.invalid = 1'b1;  // no side effects downstream
      end
    endcase
  end

endmodule

// File: gpr_file.sv
// 32 x 64 general register file, two async read ports, one write port
`timescale 1ns/1ns

module gpr_file
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  gpr_addr_t i_raddr1,
  output xlen_t     o_rdata1,
  input  gpr_addr_t i_raddr2,
  output xlen_t     o_rdata2,
  input  logic      i_we,
  input  gpr_addr_t i_waddr,
  input  xlen_t     i_wdata
);

  xlen_t regs [32];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != GPR_ZERO)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hard zero, no bypass from the write port
  assign o_rdata1 = (i_raddr1 == GPR_ZERO) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == GPR_ZERO) ? '0 : regs[i_raddr2];

endmodule

// File: id_issue.sv
// raw hazard stall, branch resolution and valid/allowin handshake
`timescale 1ns/1ns

module id_issue
  import id_pkg::*;
(
  input  logic      i_valid,
  input  xlen_t     i_pc,
  input  xlen_t     i_fs_pc,
  dec_if.consumer   i_dec,
  input  xlen_t     i_rs1_data,
  input  xlen_t     i_rs2_data,
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  input  logic      i_es_allowin,
  output gpr_addr_t o_raddr1,
  output gpr_addr_t o_raddr2,
  output logic      o_ds_allowin,
  output logic      o_ds_to_es_valid,
  output logic      o_br_taken,
  output xlen_t     o_br_target
);

  logic  hazard;
  logic  br_cond;
  logic  redirect_pending;
  logic  ds_ready_go;
  xlen_t jalr_sum;

  // a pending write to x0 never blocks
  function automatic logic rd_hit(input gpr_addr_t rd, input gpr_addr_t rs1,
                                  input gpr_addr_t rs2);
    return (rd != GPR_ZERO) && ((rd == rs1) || (rd == rs2));
  endfunction

  assign o_raddr1 = i_dec.rs1;
  assign o_raddr2 = i_dec.rs2;

  assign hazard = rd_hit(i_es_rd, i_dec.rs1, i_dec.rs2)
               || rd_hit(i_ms_rd, i_dec.rs1, i_dec.rs2)
               || rd_hit(i_ws_rd, i_dec.rs1, i_dec.rs2);

  always_comb begin
    case (i_dec.br_func)
      BR_BEQ:  br_cond = (i_rs1_data == i_rs2_data);
      BR_BNE:  br_cond = (i_rs1_data != i_rs2_data);
      BR_BLT:  br_cond = ($signed(i_rs1_data) <  $signed(i_rs2_data));
      BR_BGE:  br_cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      BR_BLTU: br_cond = (i_rs1_data <  i_rs2_data);
      BR_BGEU: br_cond = (i_rs1_data >= i_rs2_data);
      default: br_cond = 1'b0;  // 010/011 unused
    endcase
  end

  assign jalr_sum    = i_rs1_data + i_dec.imm;
  assign o_br_target = i_dec.jump_reg ? {jalr_sum[63:1], 1'b0} : i_pc + i_dec.imm;
  assign o_br_taken  = i_valid && ((i_dec.br_en && br_cond) || i_dec.jump);

  // hold until fetch is already on the target path
  assign redirect_pending = o_br_taken && (i_fs_pc != o_br_target);

  assign ds_ready_go      = !hazard && !redirect_pending;
  assign o_ds_allowin     = !i_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = i_valid && ds_ready_go;

endmodule

// File: id_stage.sv
// decode stage top, latch, decoder, register file and issue logic
`timescale 1ns/1ns

module id_stage
  import id_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst_n,
  // from fetch
  input  logic      i_fs_to_ds_valid,
  input  inst_t     i_fs_inst,
  input  xlen_t     i_fs_pc,
  output logic      o_ds_allowin,
  input  logic      i_es_allowin,
  // downstream destinations
  input  gpr_addr_t i_es_rd,
  input  gpr_addr_t i_ms_rd,
  input  gpr_addr_t i_ws_rd,
  // write back
  input  logic      i_rf_we,
  input  gpr_addr_t i_rf_waddr,
  input  xlen_t     i_rf_wdata,
  // to execute
  output logic      o_ds_to_es_valid,
  output xlen_t     o_pc,
  output xlen_t     o_rs1_data,
  output xlen_t     o_rs2_data,
  output xlen_t     o_imm,
  output gpr_addr_t o_rd,
  output alu_op_t   o_alu_op,
  output logic      o_alu_src1_pc,
  output logic      o_alu_src1_zero,
  output src2_sel_t o_alu_src2,
  output logic      o_alu_word,
  output logic      o_gpr_we,
  output logic      o_mem_re,
  output logic      o_mem_we,
  output mem_op_t   o_mem_op,
  output logic      o_invalid,
  // redirect to fetch
  output logic      o_br_taken,
  output xlen_t     o_br_target
);

  logic      ds_valid;
  inst_t     ds_inst;
  xlen_t     ds_pc;
  gpr_addr_t raddr1;
  gpr_addr_t raddr2;

  dec_if u_dec_if ();

  id_latch u_latch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_allowin        (o_ds_allowin),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .o_valid          (ds_valid),
    .o_inst           (ds_inst),
    .o_pc             (ds_pc)
  );

  id_decoder u_decoder (
    .i_inst (ds_inst),
    .o_dec  (u_dec_if.producer)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (raddr1),
    .o_rdata1 (o_rs1_data),
    .i_raddr2 (raddr2),
    .o_rdata2 (o_rs2_data),
    .i_we     (i_rf_we),
    .i_waddr  (i_rf_waddr),
    .i_wdata  (i_rf_wdata)
  );

  id_issue u_issue (
    .i_valid          (ds_valid),
    .i_pc             (ds_pc),
    .i_fs_pc          (i_fs_pc),
    .i_dec            (u_dec_if.consumer),
    .i_rs1_data       (o_rs1_data),
    .i_rs2_data       (o_rs2_data),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd),
    .i_es_allowin     (i_es_allowin),
    .o_raddr1         (raddr1),
    .o_raddr2         (raddr2),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_br_taken       (o_br_taken),
    .o_br_target      (o_br_target)
  );

  // decoded fields go out unregistered, they hold with the latch
  assign o_pc            = ds_pc;
  assign o_imm           = u_dec_if.imm;
  assign o_rd            = u_dec_if.rd;
  assign o_alu_op        = u_dec_if.alu_op;
  assign o_alu_src1_pc   = u_dec_if.alu_src1_pc;
  assign o_alu_src1_zero = u_dec_if.alu_src1_zero;
  assign o_alu_src2      = u_dec_if.alu_src2;
  assign o_alu_word      = u_dec_if.alu_word;
  assign o_gpr_we        = u_dec_if.gpr_we;
  assign o_mem_re        = u_dec_if.mem_re;
  assign o_mem_we        = u_dec_if.mem_we;
  assign o_mem_op        = u_dec_if.mem_op;
  assign o_invalid       = u_dec_if.invalid;

endmodule

// File: tb_id_stage.sv
// testbench for the decode stage, with reference decode, register model, monitor and watchdog
`timescale 1ns/1ns

module tb_id_stage
  import id_pkg::*;
();

  localparam int TOTAL_CYCLES = 20 + 200 * 14 + 41 * 3 + 41 * 14 + 16 * 20 + 80 * 14 + 40;

  logic      i_clk = 1'b0;
  logic      i_rst_n, i_fs_to_ds_valid, i_es_allowin, i_rf_we;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc, i_rf_wdata;
  gpr_addr_t i_es_rd, i_ms_rd, i_ws_rd, i_rf_waddr;
  logic      o_ds_allowin, o_ds_to_es_valid, o_alu_src1_pc, o_alu_src1_zero, o_alu_word;
  logic      o_gpr_we, o_mem_re, o_mem_we, o_invalid, o_br_taken;
  xlen_t     o_pc, o_rs1_data, o_rs2_data, o_imm, o_br_target;
  gpr_addr_t o_rd;
  alu_op_t   o_alu_op;
  src2_sel_t o_alu_src2;
  mem_op_t   o_mem_op;

  int        seed = 22541;
  int        checks = 0;
  int        errors = 0;
  xlen_t     model [32];
  inst_t     exp_inst;
  xlen_t     exp_pc;
  opcode_t   opc_tab [13] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                              OPC_STORE, OPC_OPIMM, OPC_OP, OPC_OPIMM32, OPC_OP32,
                              7'b0001111, 7'b1111111};

  id_stage dut0 (.*);

  always #10 i_clk = ~i_clk;

  function automatic xlen_t ref_imm(input inst_t in);
    case (in[6:0])
      OPC_LUI, OPC_AUIPC: return {{32{in[31]}}, in[31:12], 12'b0};
      OPC_JAL: return {{44{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
      OPC_BRANCH: return {{52{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
      OPC_STORE: return {{52{in[31]}}, in[31:25], in[11:7]};
      OPC_JALR, OPC_LOAD, OPC_OPIMM, OPC_OPIMM32: return {{52{in[31]}}, in[31:20]};
      default: return '0;
    endcase
  endfunction

  // only sub, sra and srai (and word forms) use funct7 bit 5
  function automatic alu_op_t ref_alu(input inst_t in);
    logic [2:0] f3;
    logic       is_sub;
    logic       is_sra;
    f3 = in[14:12];
    is_sub = (in[6:0] == OPC_OP || in[6:0] == OPC_OP32) && f3 == 3'b000 && in[30];
    is_sra = f3 == 3'b101 && in[30];
    case (in[6:0])
      OPC_OP, OPC_OP32, OPC_OPIMM, OPC_OPIMM32: return {is_sub || is_sra, f3};
      default: return ALU_ADD;
    endcase
  endfunction

  // {gpr_we, mem_re, mem_we, invalid, src1_pc, src1_zero, word, src2, mem_op}
  function automatic logic [11:0] ref_ctrl(input inst_t in);
    logic [2:0] f3;
    f3 = in[14:12];
    case (in[6:0])
      OPC_LUI:                return {7'b1000010, SRC2_IMM, f3};
      OPC_AUIPC:              return {7'b1000100, SRC2_IMM, f3};
      OPC_JAL, OPC_JALR:      return {7'b1000100, SRC2_FOUR, f3};
      OPC_BRANCH:             return {7'b0000000, SRC2_RS2, f3};
      OPC_LOAD:               return {7'b1100000, SRC2_IMM, f3};
      OPC_STORE:              return {7'b0010000, SRC2_IMM, f3};
      OPC_OPIMM:              return {7'b1000000, SRC2_IMM, f3};
      OPC_OPIMM32:            return {7'b1000001, SRC2_IMM, f3};
      OPC_OP:                 return {7'b1000000, SRC2_RS2, f3};
      OPC_OP32:               return {7'b1000001, SRC2_RS2, f3};
      default:                return {7'b0001000, SRC2_IMM, f3};
    endcase
  endfunction

  // returns {taken, target} with operands from the register model
  function automatic logic [64:0] ref_branch(input inst_t in, input xlen_t pc);
    xlen_t a, b, t;
    logic  tk;
    a = model[in[19:15]];
    b = model[in[24:20]];
    t = pc + ref_imm(in);
    tk = 1'b0;
    if (in[6:0] == OPC_JAL) tk = 1'b1;
    if (in[6:0] == OPC_JALR) begin
      tk = 1'b1;
      t = (a + ref_imm(in)) & ~64'd1;
    end
    if (in[6:0] == OPC_BRANCH) begin
      case (in[14:12])
        3'd0: tk = (a == b);
        3'd1: tk = (a != b);
        3'd4: tk = ($signed(a) < $signed(b));
        3'd5: tk = ($signed(a) >= $signed(b));
        3'd6: tk = (a < b);
        3'd7: tk = (a >= b);
        default: tk = 1'b0;
      endcase
    end
    return {tk, t};
  endfunction

  task automatic check_x(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_a(input string name, input gpr_addr_t got, input gpr_addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_op(input string name, input alu_op_t got, input alu_op_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input src2_sel_t got, input src2_sel_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_mop(input string name, input mem_op_t got, input mem_op_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_b(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic fail_msg(input string what);
    errors++;
    $display("%0t error: %s", $time, what);
  endtask

  // expected bundle follows every real handoff
  always @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      exp_inst <= i_fs_inst;
      exp_pc   <= i_fs_pc;
    end
  end

  always @(negedge i_clk) begin
    logic [64:0] br;
    logic [11:0] ctrl;
    if (i_rst_n && o_ds_to_es_valid) begin
      br = ref_branch(exp_inst, exp_pc);
      ctrl = ref_ctrl(exp_inst);
      check_x("o_pc", o_pc, exp_pc);
      check_x("o_imm", o_imm, ref_imm(exp_inst));
      check_a("o_rd", o_rd, exp_inst[11:7]);
      check_op("o_alu_op", o_alu_op, ref_alu(exp_inst));
      check_b("o_gpr_we", o_gpr_we, ctrl[11]);
      check_b("o_mem_re", o_mem_re, ctrl[10]);
      check_b("o_mem_we", o_mem_we, ctrl[9]);
      check_b("o_invalid", o_invalid, ctrl[8]);
      check_b("o_alu_src1_pc", o_alu_src1_pc, ctrl[7]);
      check_b("o_alu_src1_zero", o_alu_src1_zero, ctrl[6]);
      check_b("o_alu_word", o_alu_word, ctrl[5]);
      check_sel("o_alu_src2", o_alu_src2, ctrl[4:3]);
      check_mop("o_mem_op", o_mem_op, ctrl[2:0]);
      check_x("o_rs1_data", o_rs1_data, model[exp_inst[19:15]]);
      check_x("o_rs2_data", o_rs2_data, model[exp_inst[24:20]]);
      check_b("o_br_taken", o_br_taken, br[64]);
      if (br[64]) check_x("o_br_target", o_br_target, br[63:0]);
    end
  end

  function automatic inst_t rand_inst(input opcode_t opc);
    inst_t r;
    r = $random(seed);
    return {r[31:7], opc};
  endfunction

  // haz 1 or 2 blocks rs1 through es or ms, haz 3 blocks rs2 through ws
  task automatic issue(input inst_t inst, input xlen_t pc, input int haz);
    int          n;
    logic [64:0] br;
    @(posedge i_clk);
    if (haz == 1) i_es_rd <= inst[19:15];
    if (haz == 2) i_ms_rd <= inst[19:15];
    if (haz == 3) i_ws_rd <= inst[24:20];
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst <= inst;
    i_fs_pc <= pc;
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!o_ds_allowin && n < 50);
    if (n >= 50) fail_msg("instruction never accepted");
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    br = ref_branch(inst, pc);
    if (haz != 0 || br[64]) begin
      repeat (3) begin
        @(negedge i_clk);
        if (o_ds_to_es_valid || o_ds_allowin) fail_msg("stalled instruction moved on");
      end
      @(posedge i_clk);
      i_es_rd <= '0;
      i_ms_rd <= '0;
      i_ws_rd <= '0;
      if (br[64]) i_fs_pc <= br[63:0];
    end
    n = 0;
    do begin
      @(negedge i_clk);
      n++;
    end while (!(o_ds_to_es_valid && i_es_allowin) && n < 50);
    if (n >= 50) fail_msg("instruction never forwarded");
  endtask

  task automatic wb_write(input gpr_addr_t a, input xlen_t d);
    @(posedge i_clk);
    i_rf_we <= 1'b1;
    i_rf_waddr <= a;
    i_rf_wdata <= d;
    if (a != GPR_ZERO) model[a] = d;
    @(posedge i_clk);
    i_rf_we <= 1'b0;
  endtask

  task automatic report(input string name, input int e0);
    $display("test %-12s %0d errors, %0d checks so far", name, errors - e0, checks);
  endtask

  initial begin
    #(TOTAL_CYCLES * 20 * 2);
    $display("watchdog expired, simulation hung");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int    e0;
    inst_t a;
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_es_allowin = 1'b1;
    i_rf_we = 1'b0;
    i_fs_inst = '0;
    i_fs_pc = '0;
    i_rf_wdata = '0;
    i_rf_waddr = '0;
    {i_es_rd, i_ms_rd, i_ws_rd} = '0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (10) @(posedge i_clk);
    i_rst_n <= 1'b1;

    e0 = errors;
    @(negedge i_clk);
    check_b("o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check_b("o_br_taken", o_br_taken, 1'b0);
    check_b("o_ds_allowin", o_ds_allowin, 1'b1);
    issue({7'd0, 5'd7, 5'd5, 3'd0, 5'd1, OPC_OP}, 64'h1000, 0);
    report("reset", e0);

    e0 = errors;
    for (int i = 0; i < 200; i++) begin
      issue(rand_inst(opc_tab[{$random(seed)} % 13]), 64'h2000 + 4 * i, 0);
    end
    report("decode", e0);

    e0 = errors;
    for (int i = 0; i < 40; i++) wb_write(i[4:0], {$random(seed), $random(seed)});
    for (int i = 0; i < 40; i++) issue(rand_inst(OPC_OP), 64'h3000 + 4 * i, 0);
    wb_write(GPR_ZERO, '1);
    issue({7'd0, 5'd9, GPR_ZERO, 3'd0, 5'd1, OPC_OP}, 64'h30a0, 0);  // x0 after a write
    report("regfile", e0);

    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      a = rand_inst(OPC_OP);
      a[19:15] = a[19:15] | 5'd1;
      a[24:20] = a[24:20] | 5'd1;
      issue(a, 64'h4000 + 4 * i, 1 + i % 3);
    end
    report("hazard", e0);

    e0 = errors;
    for (int i = 0; i < 80; i++) begin
      issue(rand_inst(i % 8 == 0 ? OPC_JAL : (i % 8 == 1 ? OPC_JALR : OPC_BRANCH)),
            64'h5000 + 8 * i, 0);
    end
    report("branch", e0);

    e0 = errors;
    @(posedge i_clk);
    i_es_allowin <= 1'b0;
    i_fs_to_ds_valid <= 1'b1;
    i_fs_inst <= {7'd0, 5'd2, 5'd3, 3'd0, 5'd4, OPC_OP};
    i_fs_pc <= 64'h6000;
    @(posedge i_clk);
    i_fs_inst <= {12'h123, 5'd6, 3'd0, 5'd8, OPC_OPIMM};
    i_fs_pc <= 64'h6004;
    repeat (4) begin
      @(negedge i_clk);
      check_b("o_ds_allowin", o_ds_allowin, 1'b0);
      check_x("o_pc", o_pc, 64'h6000);
    end
    @(posedge i_clk);
    i_es_allowin <= 1'b1;
    @(posedge i_clk);
    i_fs_to_ds_valid <= 1'b0;
    @(negedge i_clk);
    check_b("o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
    check_x("o_pc", o_pc, 64'h6004);
    report("backpressure", e0);

    repeat (3) @(posedge i_clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
id_pkg.sv
dec_if.sv
id_latch.sv
id_decoder.sv
gpr_file.sv
id_issue.sv
id_stage.sv
tb_id_stage.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_id_stage -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
